// File: common/ahb_pkg.sv
package ahb_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Transfer type
    ///////////////////////////////////////////////////////////////////////

    typedef logic [1:0] trans_t;

    localparam trans_t HTRANS_IDLE   = 2'b00;
    localparam trans_t HTRANS_BUSY   = 2'b01;   // Master inserts a gap in a burst
    localparam trans_t HTRANS_NONSEQ = 2'b10;   // First beat of a request
    localparam trans_t HTRANS_SEQ    = 2'b11;

    ///////////////////////////////////////////////////////////////////////
    // Burst type
    ///////////////////////////////////////////////////////////////////////

    typedef logic [2:0] burst_t;

    // Incrementing codes only
    localparam burst_t HBURST_SINGLE = 3'b000;
    localparam burst_t HBURST_INCR   = 3'b001;  // Undefined length
    localparam burst_t HBURST_INCR4  = 3'b011;
    localparam burst_t HBURST_INCR8  = 3'b101;
    localparam burst_t HBURST_INCR16 = 3'b111;

    // Byte step between beats of word transfers
    localparam int WORD_STEP = 4;

endpackage

// File: common/master_pkg.sv
package master_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Entries per data FIFO
    localparam int FIFO_DEPTH = 16;

    localparam int LEN_W = 4;   // Beat count minus one

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  len_t;

    // FIFO fill level, 0 up to a full FIFO
    typedef logic [4:0] level_t;

    // Transaction controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_NONSEQ,
        ST_BUSY,
        ST_SEQ,
        ST_DRAIN    // Read burst waits for its last data phase
    } ctrl_state_t;

endpackage

// File: source/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo
    import master_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic   i_clk,
    input  logic   i_reset_n,
    input  logic   i_push,
    input  data_t  i_data,
    input  logic   i_pop,
    output data_t  o_data,
    output logic   o_empty,
    output logic   o_full,
    output level_t o_level
);

    localparam int PTR_W = $clog2(DEPTH);

    data_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    level_t           level_q;
    logic             push_en;
    logic             pop_en;

    assign o_empty = (level_q == '0);
    assign o_full  = (level_q == level_t'(DEPTH));
    assign o_level = level_q;
    assign o_data  = mem[rd_ptr_q];     // Head word falls through

    // Overflow and underflow requests are dropped
    assign push_en = i_push && !o_full;
    assign pop_en  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (push_en) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at power-of-two depth
            end
            if (pop_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;    // Both or neither
            endcase
        end
    end

endmodule

// File: ahb_master/ahb_txn_ctrl.sv
`timescale 1ns/1ps

module ahb_txn_ctrl
    import ahb_pkg::*, master_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset_n,

    input  logic   i_req_valid,
    input  logic   i_req_read,
    input  addr_t  i_req_addr,
    input  len_t   i_req_len,
    output logic   o_req_ready,

    input  level_t i_wr_level,
    input  level_t i_rd_level,
    output logic   o_wr_pop,
    output logic   o_rd_push,
    input  logic   i_hready,

    output logic   o_hsel,
    output addr_t  o_haddr,
    output trans_t o_htrans,
    output burst_t o_hburst,
    output logic   o_hwrite
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic   req_loaded_q;   // Accepted but not yet on the bus
    logic   req_read_q;
    len_t   req_len_q;
    burst_t req_burst_q;
    len_t   beat_cnt_q;
    addr_t  haddr_q;
    trans_t htrans_q;
    logic   hsel_q;
    logic   dphase_valid_q;
    logic   dphase_read_q;

    logic   req_take;
    logic   start;
    logic   beat_done;
    logic   last_beat;
    logic   wr_claim;
    logic   rd_claim;
    level_t wr_avail;
    level_t rd_free;
    logic   room_one;
    logic   room_two;

    assign o_req_ready = (state_q == ST_IDLE) && !req_loaded_q;
    assign req_take    = i_req_valid && o_req_ready;
    assign start       = (state_q == ST_IDLE) && (state_d == ST_NONSEQ);
    assign beat_done   = i_hready && (state_q == ST_NONSEQ || state_q == ST_SEQ);
    assign last_beat   = (beat_cnt_q == req_len_q);

    //////////////////////////////////////////////////////////////////////
    // FIFO room for upcoming beats
    //////////////////////////////////////////////////////////////////////

    // A started data phase already owns one word or one slot
    assign wr_claim = dphase_valid_q && !dphase_read_q;
    assign rd_claim = dphase_valid_q && dphase_read_q;

    assign wr_avail = i_wr_level - level_t'(wr_claim);
    assign rd_free  = level_t'(FIFO_DEPTH) - i_rd_level - level_t'(rd_claim);

    assign room_one = req_read_q ? (rd_free != '0) : (wr_avail != '0);
    assign room_two = req_read_q ? (rd_free >= 2) : (wr_avail >= 2);    // This beat and the next

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_loaded_q && room_one) begin
                    state_d = ST_NONSEQ;
                end
            end
            ST_NONSEQ, ST_SEQ: begin
                if (i_hready) begin
                    if (last_beat) begin
                        // Read bursts wait for the final word
                        state_d = (req_read_q && req_len_q != '0) ? ST_DRAIN : ST_IDLE;
                    end else if (room_two) begin
                        state_d = ST_SEQ;
                    end else begin
                        state_d = ST_BUSY;
                    end
                end
            end
            ST_BUSY: begin
                if (i_hready && room_one) begin
                    state_d = ST_SEQ;
                end
            end
            ST_DRAIN: begin
                if (i_hready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state_q      <= ST_IDLE;
            req_loaded_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (req_take) begin
                req_loaded_q <= 1'b1;
            end else if (start) begin
                req_loaded_q <= 1'b0;
            end
        end
    end

    // Request capture, beat count and address
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            req_read_q  <= 1'b0;
            req_len_q   <= '0;
            req_burst_q <= HBURST_SINGLE;
            beat_cnt_q  <= '0;
            haddr_q     <= '0;
        end else if (req_take) begin
            req_read_q <= i_req_read;
            req_len_q  <= i_req_len;
            beat_cnt_q <= '0;
            haddr_q    <= i_req_addr;
            case (i_req_len)
                len_t'(0):  req_burst_q <= HBURST_SINGLE;
                len_t'(3):  req_burst_q <= HBURST_INCR4;
                len_t'(7):  req_burst_q <= HBURST_INCR8;
                len_t'(15): req_burst_q <= HBURST_INCR16;
                default:    req_burst_q <= HBURST_INCR;
            endcase
        end else if (beat_done) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            haddr_q    <= haddr_q + addr_t'(WORD_STEP);    // BUSY shows the next address
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus control and data phase tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            htrans_q <= HTRANS_IDLE;
            hsel_q   <= 1'b0;
        end else begin
            hsel_q <= (state_d == ST_NONSEQ) || (state_d == ST_BUSY) || (state_d == ST_SEQ);
            case (state_d)
                ST_NONSEQ: htrans_q <= HTRANS_NONSEQ;
                ST_BUSY:   htrans_q <= HTRANS_BUSY;
                ST_SEQ:    htrans_q <= HTRANS_SEQ;
                default:   htrans_q <= HTRANS_IDLE;
            endcase
        end
    end

    // Data phase follows each completed NONSEQ or SEQ address phase
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            dphase_valid_q <= 1'b0;
            dphase_read_q  <= 1'b0;
        end else if (i_hready) begin
            dphase_valid_q <= beat_done;
            dphase_read_q  <= req_read_q;
        end
    end

    assign o_wr_pop  = i_hready && wr_claim;
    assign o_rd_push = i_hready && rd_claim;

    assign o_hsel   = hsel_q;
    assign o_haddr  = haddr_q;
    assign o_htrans = htrans_q;
    assign o_hburst = req_burst_q;
    assign o_hwrite = !req_read_q;

endmodule

// File: ahb_master/ahb_master.sv
`timescale 1ns/1ps

module ahb_master
    import ahb_pkg::*, master_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset_n,

    // IP request channel
    input  logic   i_req_valid,
    input  logic   i_req_read,
    input  addr_t  i_req_addr,
    input  len_t   i_req_len,
    output logic   o_req_ready,

    // IP write data channel
    input  logic   i_wdata_valid,
    input  data_t  i_wdata,
    output logic   o_wdata_ready,

    // IP read data channel
    output logic   o_rdata_valid,
    output data_t  o_rdata,
    input  logic   i_rdata_ready,

    // AHB master side
    output logic   o_hsel,
    output addr_t  o_haddr,
    output trans_t o_htrans,
    output burst_t o_hburst,
    output logic   o_hwrite,
    output data_t  o_hwdata,
    input  data_t  i_hrdata,
    input  logic   i_hready
);

    level_t wr_level;
    level_t rd_level;
    logic   wr_full;
    logic   rd_empty;
    logic   wr_pop;
    logic   rd_push;

    assign o_wdata_ready = !wr_full;
    assign o_rdata_valid = !rd_empty;

    //////////////////////////////////////////////////////////////////////
    // Data FIFOs
    //////////////////////////////////////////////////////////////////////

    // IP write words, head drives HWDATA
    beat_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_wr_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (i_wdata_valid && o_wdata_ready),
        .i_data    (i_wdata),
        .i_pop     (wr_pop),
        .o_data    (o_hwdata),
        .o_empty   (),
        .o_full    (wr_full),
        .o_level   (wr_level)
    );

    // Bus read words on their way to the IP
    beat_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_rd_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (rd_push),
        .i_data    (i_hrdata),
        .i_pop     (o_rdata_valid && i_rdata_ready),
        .o_data    (o_rdata),
        .o_empty   (rd_empty),
        .o_full    (),
        .o_level   (rd_level)
    );

    //////////////////////////////////////////////////////////////////////
    // Transaction controller
    //////////////////////////////////////////////////////////////////////

    ahb_txn_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_req_valid (i_req_valid),
        .i_req_read  (i_req_read),
        .i_req_addr  (i_req_addr),
        .i_req_len   (i_req_len),
        .o_req_ready (o_req_ready),
        .i_wr_level  (wr_level),
        .i_rd_level  (rd_level),
        .o_wr_pop    (wr_pop),
        .o_rd_push   (rd_push),
        .i_hready    (i_hready),
        .o_hsel      (o_hsel),
        .o_haddr     (o_haddr),
        .o_htrans    (o_htrans),
        .o_hburst    (o_hburst),
        .o_hwrite    (o_hwrite)
    );

endmodule

// File: test/ahb_slave_model.sv
`timescale 1ns/1ps

module ahb_slave_model
    import ahb_pkg::*, master_pkg::*;
#(
    parameter int WORDS = 256,
    parameter int SEED  = 14
) (
    input  logic   i_clk,
    input  logic   i_reset_n,
    input  logic   i_hsel,
    input  addr_t  i_haddr,
    input  trans_t i_htrans,
    input  logic   i_hwrite,
    input  data_t  i_hwdata,
    output data_t  o_hrdata,
    output logic   o_hready
);

    localparam int IDX_W = $clog2(WORDS);

    data_t            mem [WORDS];
    integer           seed;
    logic             dp_valid_q;   // Data phase in progress
    logic             dp_write_q;
    logic [IDX_W-1:0] dp_idx_q;
    logic             ready_q;
    logic             addr_take;

    initial begin
        seed = SEED;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = data_t'(i * 32'h0101_0101) ^ 32'h5A5A_0000;  // Every index bit shows
        end
    end

    // Wait states only while a data phase is pending
    assign o_hready  = dp_valid_q ? ready_q : 1'b1;
    assign o_hrdata  = (dp_valid_q && !dp_write_q) ? mem[dp_idx_q] : '0;
    assign addr_take = i_hsel && (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ);

    always @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
            dp_idx_q   <= '0;
            ready_q    <= 1'b1;
        end else begin
            ready_q <= (($random(seed) & 3) != 0);  // Ready on about 3 of 4 cycles
            if (o_hready) begin
                dp_valid_q <= addr_take;
                dp_write_q <= i_hwrite;
                dp_idx_q   <= i_haddr[IDX_W+1:2];
            end
        end
    end

    always @(posedge i_clk) begin
        if (dp_valid_q && dp_write_q && o_hready) begin
            mem[dp_idx_q] <= i_hwdata;
        end
    end

endmodule

// File: test/tb_ahb_master.sv
`timescale 1ns/1ps

module tb_ahb_master
    import ahb_pkg::*, master_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT    = 2000;     // Cycles per wait
    localparam int MEM_WORDS  = 256;

    typedef enum int {
        UNTIL_ACCEPTED,
        UNTIL_REQ_READY,
        UNTIL_READS_DONE,
        UNTIL_WRITES_LANDED,
        UNTIL_BUSY
    } wait_t;

    logic   clk;
    logic   reset_n;
    logic   req_valid;
    logic   req_read;
    addr_t  req_addr;
    len_t   req_len;
    logic   req_ready;
    logic   wdata_valid;
    data_t  wdata;
    logic   wdata_ready;
    logic   rdata_valid;
    data_t  rdata;
    logic   rdata_ready;
    logic   hsel;
    addr_t  haddr;
    trans_t htrans;
    burst_t hburst;
    logic   hwrite;
    data_t  hwdata;
    data_t  hrdata;
    logic   hready;

    integer seed;
    integer ready_seed;
    int     check_cnt;
    int     err_cnt;
    int     timeout_cnt;
    data_t  model_mem [MEM_WORDS];
    data_t  wr_queue [$];     // Words waiting for the write channel
    data_t  rd_expect [$];    // Words the read channel still owes
    int     accept_cnt;
    int     accept_goal;
    int     wr_issued;
    int     wr_pushed;
    int     wr_landed;

    // Monitor state
    logic   txn_active;
    logic   txn_read;
    addr_t  txn_addr;
    int     txn_beats;
    int     addr_beats;
    logic   dp_pending;
    logic   dp_write;
    logic   dp_ends_txn;
    logic   ready_due;

    ahb_master i_ahb_master (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_req_valid   (req_valid),
        .i_req_read    (req_read),
        .i_req_addr    (req_addr),
        .i_req_len     (req_len),
        .o_req_ready   (req_ready),
        .i_wdata_valid (wdata_valid),
        .i_wdata       (wdata),
        .o_wdata_ready (wdata_ready),
        .o_rdata_valid (rdata_valid),
        .o_rdata       (rdata),
        .i_rdata_ready (rdata_ready),
        .o_hsel        (hsel),
        .o_haddr       (haddr),
        .o_htrans      (htrans),
        .o_hburst      (hburst),
        .o_hwrite      (hwrite),
        .o_hwdata      (hwdata),
        .i_hrdata      (hrdata),
        .i_hready      (hready)
    );

    ahb_slave_model #(
        .WORDS (MEM_WORDS),
        .SEED  (14)
    ) u_slave (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .i_hsel    (hsel),
        .i_haddr   (haddr),
        .i_htrans  (htrans),
        .i_hwrite  (hwrite),
        .i_hwdata  (hwdata),
        .o_hrdata  (hrdata),
        .o_hready  (hready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Checks and waits
    ////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (exp === act) else begin
            err_cnt++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input string what, input bit ok);
        check_cnt++;
        assert (ok) else begin
            err_cnt++;
            $display("Error: %s", what);
        end
    endtask

    function automatic bit reached(input wait_t what);
        case (what)
            UNTIL_ACCEPTED:      return accept_cnt >= accept_goal;
            UNTIL_REQ_READY:     return req_ready;
            UNTIL_READS_DONE:    return rd_expect.size() == 0;
            UNTIL_WRITES_LANDED: return wr_landed == wr_issued;
            default:             return htrans == HTRANS_BUSY;
        endcase
    endfunction

    // Polled on falling edges, where outputs are settled
    task automatic wait_until(input wait_t what, input string label);
        int n;
        for (n = 0; n < TIMEOUT && !reached(what); n++) begin
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            timeout_cnt++;
            $display("Timeout: %s did not happen within %0d cycles", label, TIMEOUT);
        end
    endtask

    // Expected burst type from the beat count
    function automatic burst_t burst_for(input int beats);
        case (beats)
            1:       return HBURST_SINGLE;
            4:       return HBURST_INCR4;
            8:       return HBURST_INCR8;
            16:      return HBURST_INCR16;
            default: return HBURST_INCR;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // IP side stimulus
    ////////////////////////////////////////////////////////////////////

    task automatic pick_request(input int n, output addr_t addr, output len_t len);
        int idx;
        idx  = {$random(seed)} % (MEM_WORDS - 16);
        addr = addr_t'(idx * WORD_STEP);
        case (n)
            0:       len = len_t'(0);
            1:       len = len_t'(3);
            2:       len = len_t'(7);
            3:       len = len_t'(15);
            default: len = len_t'($random(seed));
        endcase
    endtask

    task automatic issue_request(input logic read, input addr_t addr, input len_t len);
        accept_goal = accept_cnt + 1;
        @(negedge clk);
        req_valid = 1'b1;
        req_read  = read;
        req_addr  = addr;
        req_len   = len;
        wait_until(UNTIL_ACCEPTED, "request acceptance");
        req_valid = 1'b0;
    endtask

    // Starve keeps all but the first word back for a while
    task automatic run_write(input addr_t addr, input len_t len, input bit starve);
        data_t words [$];
        data_t word;
        addr_t held_addr;
        int    i;
        for (i = 0; i <= len; i++) begin
            word = $random(seed);
            model_mem[addr[9:2] + i] = word;
            words.push_back(word);
        end
        wr_issued += len + 1;
        @(posedge clk);
        wr_queue.push_back(words.pop_front());
        while (!starve && words.size() != 0) begin
            wr_queue.push_back(words.pop_front());
        end
        issue_request(1'b0, addr, len);
        if (starve) begin
            wait_until(UNTIL_BUSY, "BUSY while write data is missing");
            held_addr = addr + addr_t'(WORD_STEP);    // Second beat waits for its word
            repeat (10) begin
                @(negedge clk);
                check_value("starve htrans", HTRANS_BUSY, htrans);
                check_value("starve haddr", held_addr, haddr);
            end
            @(posedge clk);
            while (words.size() != 0) begin
                wr_queue.push_back(words.pop_front());
            end
            @(negedge clk);
        end
        wait_until(UNTIL_REQ_READY, "end of write request");
    endtask

    task automatic run_read(input addr_t addr, input len_t len);
        for (int i = 0; i <= len; i++) begin
            rd_expect.push_back(model_mem[addr[9:2] + i]);
        end
        issue_request(1'b1, addr, len);
        wait_until(UNTIL_READS_DONE, "return of read data");
    endtask

    task automatic compare_memory(input string name);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value(name, model_mem[i], u_slave.mem[i]);
        end
    endtask

    // Write channel driver
    always @(negedge clk) begin
        // Ready while the write FIFO has room
        check_value("wdata_ready", (wr_pushed - wr_landed) < FIFO_DEPTH, wdata_ready);
        wdata_valid = (wr_queue.size() != 0);
        wdata       = (wr_queue.size() != 0) ? wr_queue[0] : '0;
    end

    always @(posedge clk) begin
        if (wdata_valid && wdata_ready) begin
            void'(wr_queue.pop_front());
            wr_pushed++;
        end
    end

    // Read channel with random back-pressure
    always @(negedge clk) begin
        rdata_ready = (($random(ready_seed) & 1) != 0);
    end

    always @(posedge clk) begin
        if (rdata_valid && rdata_ready) begin
            if (rd_expect.size() == 0) begin
                check_true("read word arrived with no read pending", 1'b0);
            end else begin
                check_value("read data", rd_expect.pop_front(), rdata);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Bus and handshake monitor
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (txn_active) begin
            check_value("req_ready during request", 1'b0, req_ready);
        end else if (ready_due) begin
            check_value("req_ready after request", 1'b1, req_ready);
        end
        ready_due = 1'b0;
        if (hready) begin
            if (dp_pending && dp_write) begin
                wr_landed++;
            end
            if (dp_pending && dp_ends_txn) begin
                txn_active = 1'b0;          // Last read word taken from the bus
                ready_due  = 1'b1;
            end
            dp_pending = 1'b0;
            if (hsel && htrans != HTRANS_IDLE) begin
                check_true("bus transfer outside a request", txn_active);
                if (addr_beats == 0) begin
                    check_value("first beat htrans", HTRANS_NONSEQ, htrans);
                    check_value("burst type", burst_for(txn_beats), hburst);
                end else begin
                    check_true("later beat neither SEQ nor BUSY",
                               htrans == HTRANS_SEQ || htrans == HTRANS_BUSY);
                end
                if (htrans != HTRANS_BUSY) begin
                    check_value("beat address", txn_addr + addr_t'(addr_beats * WORD_STEP), haddr);
                    check_value("direction", !txn_read, hwrite);
                    addr_beats++;
                    dp_pending  = 1'b1;
                    dp_write    = hwrite;
                    dp_ends_txn = txn_read && txn_beats > 1 && addr_beats == txn_beats;
                    if (addr_beats == txn_beats && !dp_ends_txn) begin
                        txn_active = 1'b0;
                        ready_due  = 1'b1;
                    end
                end
            end
        end
        if (req_valid && req_ready) begin
            accept_cnt++;
            txn_active = 1'b1;
            txn_read   = req_read;
            txn_addr   = req_addr;
            txn_beats  = req_len + 1;
            addr_beats = 0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        addr_t addr;
        len_t  len;
        int    i;
        clk         = 1'b0;
        reset_n     = 1'b0;
        req_valid   = 1'b0;
        req_read    = 1'b0;
        req_addr    = '0;
        req_len     = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        rdata_ready = 1'b0;
        seed        = 14;
        ready_seed  = 14;
        check_cnt   = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        accept_cnt  = 0;
        accept_goal = 0;
        wr_issued   = 0;
        wr_pushed   = 0;
        wr_landed   = 0;
        txn_active  = 1'b0;
        dp_pending  = 1'b0;
        dp_ends_txn = 1'b0;
        ready_due   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        check_value("reset htrans", HTRANS_IDLE, htrans);
        check_value("reset hsel", 1'b0, hsel);
        check_value("reset rdata_valid", 1'b0, rdata_valid);
        check_value("reset req_ready", 1'b1, req_ready);
        for (i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = u_slave.mem[i];
        end

        for (i = 0; i < 12; i++) begin
            pick_request(i, addr, len);
            run_write(addr, len, 1'b0);
        end
        wait_until(UNTIL_WRITES_LANDED, "completion of write data phases");
        compare_memory("write memory");

        for (i = 0; i < 12; i++) begin
            pick_request(i, addr, len);
            run_read(addr, len);
        end

        // INCR8 with its data held back
        pick_request(2, addr, len);
        run_write(addr, len, 1'b1);
        wait_until(UNTIL_WRITES_LANDED, "completion of starved write");
        compare_memory("starve memory");
        run_read(addr, len);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: files.f
common/ahb_pkg.sv
common/master_pkg.sv
source/beat_fifo.sv
ahb_master/ahb_txn_ctrl.sv
ahb_master/ahb_master.sv
test/ahb_slave_model.sv
test/tb_ahb_master.sv
